/* filelist.f */
rtl/bus_pkg.sv
rtl/adc_pkg.sv
rtl/periph_if.sv
rtl/mem_bus_decode.sv
rtl/drp_port.sv
rtl/adc_core.sv
rtl/sfr_block.sv
rtl/adc_periph_top.sv
testbench/adc_periph_assert.sv
testbench/tb_adc_periph.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_adc_periph
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_adc_periph.sv */
module tb_adc_periph;
    timeunit 1ns;
    timeprecision 1ps;

    import bus_pkg::*;
    import adc_pkg::*;

    localparam int          MAX_CYCLES = 20000;  // Tests need well under 1500 cycles
    localparam logic [31:0] RAND_SEED  = 32'hd34d;
    localparam bus_addr_t   SFR_ADDR   = {BASE_ADDR, WIN_SFR, 16'h0000};

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 trigger_in;
    logic [SAMPLES_W-1:0] sample_codes;
    logic                 mem_valid;
    bus_addr_t            mem_addr;
    bus_data_t            mem_wdata;
    bus_strb_t            mem_wstrb;
    logic                 mem_ready;
    bus_data_t            mem_rdata;

    // Expected state built from what the test wrote
    adc_code_t  samples    [N_CHANNELS];
    drp_data_t  exp_result [N_CHANNELS];
    drp_data_t  exp_limit  [N_CHANNELS];
    drp_data_t  exp_ot;
    logic [3:0] exp_mask;
    chan_t      exp_chan;
    int         cycles = 0;
    string      test_name;

    adc_periph_top dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .trigger_in   (trigger_in),
        .sample_codes (sample_codes),
        .mem_valid    (mem_valid),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata)
    );

    bind adc_periph_top adc_periph_assert u_assert (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .den       (drp_bus.den),
        .busy      (stat_if.busy),
        .eoc       (stat_if.eoc),
        .eos       (stat_if.eos)
    );

    always #4 clk = ~clk;  // 8 ns period

    // Hung run guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_data(input string name, input drp_data_t exp, input drp_data_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_status(input string name, input bus_data_t exp, input bus_data_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("** Error [%s] %s: expected %0d cycles, actual %0d", test_name, name,
                     exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // ----------------------------------------------------------------------
    // Bus master
    // ----------------------------------------------------------------------
    function automatic bus_addr_t reg_addr(input drp_addr_t a);
        return {BASE_ADDR, WIN_DRP, 7'h00, a, 2'b00};  // Word address in bits 8:2
    endfunction

    // Holds the request until ready and lets go on the following falling edge
    task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
                              input bus_strb_t strb, output bus_data_t rdata);
        int lat;
        int exp_lat;
        lat     = 0;
        exp_lat = (addr[23:16] == WIN_DRP && (strb == '0 || &strb)) ? 3 : 1;
        @(negedge clk);
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = strb;
        do begin
            @(negedge clk);
            lat++;
        end while (!mem_ready);
        rdata = mem_rdata;
        @(negedge clk);
        mem_valid = 1'b0;
        mem_wstrb = '0;
        check_latency($sformatf("ready at %h", addr), exp_lat, lat);
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        bus_data_t unused;
        bus_access(addr, data, '1, unused);
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        bus_access(addr, '0, '0, data);
    endtask

    // Register read with the upper half of the bus word zero
    task automatic read_reg(input drp_addr_t a, output drp_data_t v);
        bus_data_t d;
        bus_read(reg_addr(a), d);
        check_status($sformatf("upper half at %h", a), '0, {d[31:16], 16'h0000});
        v = d[15:0];
    endtask

    // Expected idle status word
    // A conversion also moves the expected results
    function automatic bus_data_t ref_status(input logic [3:0] mask, input logic converted);
        bus_data_t word;
        word = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (converted && mask[i]) begin
                exp_result[i] = drp_data_t'(samples[i]) << 4;  // Left-justified
                exp_chan      = chan_t'(i);                    // Last one converted
            end
            word[SFR_LSB_ALARM + i] = exp_result[i] >= exp_limit[i];
        end
        word[SFR_BIT_OT]                 = exp_result[0] >= exp_ot;
        word[SFR_LSB_CHANNEL +: CHAN_W] = exp_chan;
        return word;
    endfunction

    task automatic check_registers();
        drp_data_t v;
        for (int i = 0; i < N_CHANNELS; i++) begin
            read_reg(REG_RESULT0 + drp_addr_t'(i), v);
            check_data($sformatf("result %0d", i), exp_result[i], v);
            read_reg(REG_LIMIT0 + drp_addr_t'(i), v);
            check_data($sformatf("limit %0d", i), exp_limit[i], v);
        end
        read_reg(REG_OT_LIMIT, v);
        check_data("ot limit", exp_ot, v);
        read_reg(REG_SEQ_MASK, v);
        check_data("mask", drp_data_t'(exp_mask), v);
    endtask

    task automatic run_sequence(input logic [3:0] mask);
        bus_data_t d;
        bus_write(reg_addr(REG_SEQ_MASK), 32'(mask));
        exp_mask = mask;
        for (int i = 0; i < N_CHANNELS; i++) samples[i] = adc_code_t'($urandom);
        sample_codes = {samples[3], samples[2], samples[1], samples[0]};
        @(negedge clk);
        trigger_in = 1'b1;
        repeat (4) @(negedge clk);  // Outlasts the synchroniser
        trigger_in = 1'b0;
        do begin
            bus_read(SFR_ADDR, d);
        end while (d[SFR_BIT_BUSY]);
        bus_read(SFR_ADDR, d);  // Past the eoc and eos pulses
        check_status($sformatf("status, mask %b", mask), ref_status(mask, 1'b1), d);
        check_registers();
    endtask

    task automatic model_reset();
        for (int i = 0; i < N_CHANNELS; i++) begin
            exp_result[i] = '0;
            exp_limit[i]  = LIMIT_RESET;
        end
        exp_ot   = LIMIT_RESET;
        exp_mask = '0;
        exp_chan = '0;
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    initial begin
        bus_data_t d;
        void'($urandom(RAND_SEED));
        arst_n       = 1'b0;
        trigger_in   = 1'b0;
        sample_codes = '0;
        mem_valid    = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_wstrb    = '0;
        for (int i = 0; i < N_CHANNELS; i++) samples[i] = '0;
        model_reset();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        test_name = "readback";
        check_registers();  // Results zero after reset
        bus_write(reg_addr(REG_SEQ_MASK), 32'h0000_000b);
        exp_mask = 4'hb;
        for (int i = 0; i < N_CHANNELS; i++) begin
            exp_limit[i] = drp_data_t'($urandom);
            bus_write(reg_addr(REG_LIMIT0 + drp_addr_t'(i)), 32'(exp_limit[i]));
        end
        exp_ot = 16'h8000;
        bus_write(reg_addr(REG_OT_LIMIT), 32'(exp_ot));
        check_registers();

        test_name = "conversion";
        run_sequence(4'hf);
        run_sequence(4'h5);  // Channels 1 and 3 keep old values
        run_sequence(4'h8);

        test_name = "alarms";
        exp_limit[0] = exp_result[0];          // Equal trips
        exp_limit[1] = exp_result[1] + 16'h1;  // Just above
        exp_limit[2] = 16'h0000;               // Below anything
        exp_limit[3] = 16'hFFFF;
        for (int i = 0; i < N_CHANNELS; i++)
            bus_write(reg_addr(REG_LIMIT0 + drp_addr_t'(i)), 32'(exp_limit[i]));
        exp_ot = exp_result[0];
        bus_write(reg_addr(REG_OT_LIMIT), 32'(exp_ot));
        bus_read(SFR_ADDR, d);
        check_status("ot set", ref_status(exp_mask, 1'b0), d);
        exp_ot = exp_result[0] + 16'h1;
        bus_write(reg_addr(REG_OT_LIMIT), 32'(exp_ot));
        bus_read(SFR_ADDR, d);
        check_status("ot clear", ref_status(exp_mask, 1'b0), d);

        test_name = "core reset";
        bus_write(SFR_ADDR, 32'h0000_0001);
        model_reset();
        bus_read(SFR_ADDR, d);
        check_status("status", ref_status(exp_mask, 1'b0), d);
        check_registers();

        test_name = "timing";
        // Each access checks its own ready latency
        bus_write(reg_addr(REG_LIMIT0), 32'h0000_1230);
        exp_limit[0] = 16'h1230;
        bus_read(SFR_ADDR, d);
        bus_access(reg_addr(REG_SEQ_MASK), 32'h0000_000f, 4'b0011, d);
        check_status("partial register write rdata", '0, d);
        bus_access(SFR_ADDR, 32'h0000_0001, 4'b0001, d);  // No core reset either
        check_status("partial status write rdata", '0, d);
        check_registers();

        $display("Test OK");
        $finish;
    end

endmodule

/* testbench/adc_periph_assert.sv */
module adc_periph_assert (
    input logic clk,
    input logic arst_n,
    input logic mem_valid,
    input logic mem_ready,
    input logic den,
    input logic busy,
    input logic eoc,
    input logic eos
);
    timeunit 1ns;
    timeprecision 1ps;

    // Register port strobe, single cycle
    den_pulse: assert property (@(posedge clk) disable iff (!arst_n) den |=> !den)
        else $error("den high for more than one cycle");

    // Ready only answers a held request
    ready_valid: assert property (@(posedge clk) disable iff (!arst_n) mem_ready |-> mem_valid)
        else $error("mem_ready without mem_valid");

    // End of sequence comes with the last end of conversion
    eos_eoc: assert property (@(posedge clk) disable iff (!arst_n) eos |-> eoc)
        else $error("eos without eoc");

    busy_reset: assert property (@(posedge clk) $rose(arst_n) |-> !busy)
        else $error("busy high after reset");

endmodule

/* rtl/adc_periph_top.sv */
module adc_periph_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          trigger_in,    // Async level
    input  logic [adc_pkg::SAMPLES_W-1:0] sample_codes,  // Channel 0 in low bits
    input  logic                          mem_valid,
    input  bus_pkg::bus_addr_t            mem_addr,
    input  bus_pkg::bus_data_t            mem_wdata,
    input  bus_pkg::bus_strb_t            mem_wstrb,
    output logic                          mem_ready,
    output bus_pkg::bus_data_t            mem_rdata
);
    import bus_pkg::*;

    logic      drp_ready;
    bus_data_t drp_rdata;

    periph_req_if req_if ();
    drp_if        drp_bus ();
    adc_status_if stat_if ();

    // ----------------------------------------------------------------------
    // Decode, execute, return
    // ----------------------------------------------------------------------
    mem_bus_decode u_decode (
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .req       (req_if)
    );

    drp_port u_port (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req_if),
        .drp    (drp_bus),
        .ready  (drp_ready),
        .rdata  (drp_rdata)
    );

    adc_core u_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .trigger_in   (trigger_in),
        .sample_codes (sample_codes),
        .drp          (drp_bus),
        .status       (stat_if)
    );

    sfr_block u_sfr (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req_if),
        .status    (stat_if),
        .drp_ready (drp_ready),
        .drp_rdata (drp_rdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

/* rtl/sfr_block.sv */
module sfr_block (
    input  logic               clk,
    input  logic               arst_n,
    periph_req_if.sfr          req,
    adc_status_if.sfr          status,
    input  logic               drp_ready,
    input  bus_pkg::bus_data_t drp_rdata,
    output logic               mem_ready,
    output bus_pkg::bus_data_t mem_rdata
);
    import bus_pkg::*;
    import adc_pkg::*;

    logic      ready_q;
    logic      reset_q;
    logic      take;       // First cycle of an SFR or bad access
    bus_data_t status_word;
    bus_data_t rdata_q;

    // Status word packing
    always_comb begin
        status_word                                = '0;
        status_word[SFR_BIT_BUSY]                  = status.busy;
        status_word[SFR_BIT_EOC]                   = status.eoc;
        status_word[SFR_BIT_EOS]                   = status.eos;
        status_word[SFR_BIT_OT]                    = status.ot;
        status_word[SFR_LSB_CHANNEL +: CHAN_W]     = status.channel;
        status_word[SFR_LSB_ALARM +: ALARM_W]      = status.alm;
    end

    // No re-fire while ready is out, valid drops at that edge
    assign take = (req.hit_sfr || req.hit_bad) && !ready_q;

    // ----------------------------------------------------------------------
    // Registered acknowledge
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= 1'b0;
            reset_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            ready_q <= take;
            reset_q <= take && req.hit_sfr && req.write && req.wdata[SFR_BIT_CORE_RESET];
            // Bad accesses and writes return zero
            rdata_q <= (take && req.hit_sfr && !req.write) ? status_word : '0;
        end
    end

    assign status.core_reset = reset_q;  // One cycle pulse

    // Both sources idle at zero
    assign mem_ready = ready_q | drp_ready;
    assign mem_rdata = rdata_q | drp_rdata;

endmodule

/* rtl/adc_core.sv */
module adc_core (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          trigger_in,
    input  logic [adc_pkg::SAMPLES_W-1:0] sample_codes,
    drp_if.slave                          drp,
    adc_status_if.core                    status
);
    import adc_pkg::*;

    logic                   trig_meta, trig_sync, trig_prev;
    drp_data_t              result [N_CHANNELS];
    drp_data_t              limit  [N_CHANNELS];
    drp_data_t              ot_limit;
    logic [N_CHANNELS-1:0]  seq_mask;
    seq_state_t             state;
    logic [N_CHANNELS-1:0]  pending;   // Channels left in this sequence
    logic [CNT_W-1:0]       cnt;
    logic [CH_IDX_W-1:0]    cur;
    adc_code_t              cur_code;
    logic                   last, conv_done, start, wr_en;
    logic                   eoc_q, eos_q;
    chan_t                  chan_q;
    logic [DRP_LATENCY-1:0] lat;       // Read/write pipeline
    drp_addr_t              rd_addr;
    drp_data_t              rd_data;

    // Address inside a block of N_CHANNELS registers
    function automatic logic in_block(drp_addr_t addr, drp_addr_t base);
        drp_addr_t offs;
        offs = addr - base;
        return offs < N_CHANNELS;
    endfunction

    // ----------------------------------------------------------------------
    // Trigger synchroniser and edge detect
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trig_meta <= 1'b0;
            trig_sync <= 1'b0;
            trig_prev <= 1'b0;
        end else begin
            trig_meta <= trigger_in;
            trig_sync <= trig_meta;
            trig_prev <= trig_sync;
        end
    end

    assign start = trig_sync && !trig_prev && state == SEQ_IDLE && |seq_mask;

    // Lowest pending channel converts next
    always_comb begin
        cur = '0;
        for (int i = N_CHANNELS - 1; i >= 0; i--) begin
            if (pending[i]) cur = CH_IDX_W'(i);
        end
    end

    assign last      = (pending & (pending - 1'b1)) == '0;  // Single bit left
    assign conv_done = state == SEQ_CONVERT && cnt == CNT_W'(CONV_CYCLES - 1);
    assign cur_code  = sample_codes[cur*ADC_CODE_W +: ADC_CODE_W];

    // ----------------------------------------------------------------------
    // Sequencer and result registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n || status.core_reset) begin
            state   <= SEQ_IDLE;
            pending <= '0;
            cnt     <= '0;
            eoc_q   <= 1'b0;
            eos_q   <= 1'b0;
            chan_q  <= '0;
            for (int i = 0; i < N_CHANNELS; i++) result[i] <= '0;
        end else begin
            eoc_q <= 1'b0;
            eos_q <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state   <= SEQ_CONVERT;
                        pending <= seq_mask;  // Mask sampled at start
                        cnt     <= '0;
                    end
                end
                SEQ_CONVERT: begin
                    chan_q <= chan_t'(cur);
                    cnt    <= cnt + 1'b1;
                    if (conv_done) begin
                        result[cur]  <= {cur_code, {CODE_SHIFT{1'b0}}};
                        eoc_q        <= 1'b1;
                        pending[cur] <= 1'b0;
                        cnt          <= '0;
                        if (last) begin
                            eos_q <= 1'b1;  // Busy drops with this
                            state <= SEQ_IDLE;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Configuration registers
    // ----------------------------------------------------------------------
    assign wr_en = drp.den && drp.dwe;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n || status.core_reset) begin
            seq_mask <= '0;
            ot_limit <= LIMIT_RESET;
            for (int i = 0; i < N_CHANNELS; i++) limit[i] <= LIMIT_RESET;
        end else if (wr_en) begin
            if (drp.daddr == REG_SEQ_MASK) seq_mask <= drp.di[N_CHANNELS-1:0];
            if (drp.daddr == REG_OT_LIMIT) ot_limit <= drp.di;
            if (in_block(drp.daddr, REG_LIMIT0)) limit[drp.daddr[CH_IDX_W-1:0]] <= drp.di;
        end
    end

    // Port pipeline, not touched by core reset so an access always completes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) lat <= '0;
        else         lat <= {lat[DRP_LATENCY-2:0], drp.den};
    end

    always_ff @(posedge clk) begin
        if (drp.den) rd_addr <= drp.daddr;
    end

    always_comb begin
        rd_data = '0;  // Unmapped reads
        if (in_block(rd_addr, REG_RESULT0))     rd_data = result[rd_addr[CH_IDX_W-1:0]];
        else if (in_block(rd_addr, REG_LIMIT0)) rd_data = limit[rd_addr[CH_IDX_W-1:0]];
        else if (rd_addr == REG_SEQ_MASK)       rd_data = DRP_DATA_W'(seq_mask);
        else if (rd_addr == REG_OT_LIMIT)       rd_data = ot_limit;
    end

    assign drp.drdy = lat[DRP_LATENCY-1];
    assign drp.dout = drp.drdy ? rd_data : '0;

    // Alarms, upper limits only
    always_comb begin
        status.alm = '0;
        for (int i = 0; i < N_CHANNELS; i++) status.alm[i] = result[i] >= limit[i];
    end

    assign status.ot      = result[0] >= ot_limit;
    assign status.busy    = state == SEQ_CONVERT;
    assign status.eoc     = eoc_q;
    assign status.eos     = eos_q;
    assign status.channel = chan_q;

endmodule

/* rtl/drp_port.sv */
module drp_port (
    input  logic               clk,
    input  logic               arst_n,
    periph_req_if.port         req,
    drp_if.master              drp,
    output logic               ready,
    output bus_pkg::bus_data_t rdata
);
    import bus_pkg::*;
    import adc_pkg::*;

    drp_state_t state;
    logic       den_q;
    logic       dwe_q;
    drp_addr_t  daddr_q;
    drp_data_t  di_q;

    // ----------------------------------------------------------------------
    // One strobe per bus access
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= PORT_IDLE;
            den_q <= 1'b0;
            dwe_q <= 1'b0;
        end else begin
            den_q <= 1'b0;  // Strobes are single cycle
            dwe_q <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (req.hit_drp) begin
                        den_q <= 1'b1;
                        dwe_q <= req.write;
                        state <= PORT_WAIT;
                    end
                end
                PORT_WAIT: if (drp.drdy) state <= PORT_DONE;
                PORT_DONE: state <= PORT_IDLE;  // Valid is gone by now
                default:   state <= PORT_IDLE;
            endcase
        end
    end

    // Address and data held for the core
    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && req.hit_drp) begin
            daddr_q <= req.word_addr;
            di_q    <= req.wdata[DRP_DATA_W-1:0];
        end
    end

    assign drp.den   = den_q;
    assign drp.dwe   = dwe_q;
    assign drp.daddr = daddr_q;
    assign drp.di    = di_q;

    // Ready follows drdy in the same cycle
    assign ready = (state == PORT_WAIT) && drp.drdy;
    assign rdata = ready ? {{(BUS_DATA_W-DRP_DATA_W){1'b0}}, drp.dout} : '0;

endmodule

/* rtl/mem_bus_decode.sv */
module mem_bus_decode (
    input  logic               mem_valid,
    input  bus_pkg::bus_addr_t mem_addr,
    input  bus_pkg::bus_data_t mem_wdata,
    input  bus_pkg::bus_strb_t mem_wstrb,
    periph_req_if.decode       req
);
    import bus_pkg::*;
    import adc_pkg::*;

    logic sel_drp;
    logic sel_sfr;
    logic word_rd;
    logic word_wr;
    logic word_ok;

    // Window match on the upper half of the address
    assign sel_drp = mem_valid && (mem_addr[31:16] == {BASE_ADDR, WIN_DRP});
    assign sel_sfr = mem_valid && (mem_addr[31:16] == {BASE_ADDR, WIN_SFR});

    // Word access only
    assign word_rd = (mem_wstrb == '0);
    assign word_wr = &mem_wstrb;
    assign word_ok = word_rd || word_wr;

    assign req.hit_drp = sel_drp && word_ok;
    assign req.hit_sfr = sel_sfr && word_ok;
    assign req.hit_bad = (sel_drp || sel_sfr) && !word_ok;  // Acked, never forwarded

    assign req.write     = word_wr;
    assign req.word_addr = mem_addr[DRP_ADDR_W+1:2];  // Byte to word address
    assign req.wdata     = mem_wdata;

endmodule

/* rtl/periph_if.sv */
// Decoded bus request, level signals while the master holds it
interface periph_req_if;
    import bus_pkg::*;
    import adc_pkg::*;

    logic      hit_drp;
    logic      hit_sfr;
    logic      hit_bad;    // Window hit with partial strobes
    logic      write;
    drp_addr_t word_addr;
    bus_data_t wdata;

    modport decode (output hit_drp, hit_sfr, hit_bad, write, word_addr, wdata);
    modport port   (input hit_drp, write, word_addr, wdata);
    modport sfr    (input hit_sfr, hit_bad, write, wdata);
endinterface

// Dynamic register port
interface drp_if;
    import adc_pkg::*;

    logic      den;   // One-cycle strobe
    logic      dwe;
    drp_addr_t daddr;
    drp_data_t di;
    drp_data_t dout;  // Zero unless drdy
    logic      drdy;

    modport master (output den, dwe, daddr, di, input dout, drdy);
    modport slave  (input den, dwe, daddr, di, output dout, drdy);
endinterface

// Converter status and core reset
interface adc_status_if;
    import adc_pkg::*;

    logic   busy;
    logic   eoc;
    logic   eos;
    chan_t  channel;
    alarm_t alm;
    logic   ot;
    logic   core_reset;

    modport core (output busy, eoc, eos, channel, alm, ot, input core_reset);
    modport sfr  (input busy, eoc, eos, channel, alm, ot, output core_reset);
endinterface

/* rtl/adc_pkg.sv */
package adc_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int DRP_ADDR_W = 7;
    localparam int DRP_DATA_W = 16;
    localparam int ADC_CODE_W = 12;
    localparam int CHAN_W     = 5;
    localparam int ALARM_W    = 8;

    typedef logic [DRP_ADDR_W-1:0] drp_addr_t;
    typedef logic [DRP_DATA_W-1:0] drp_data_t;
    typedef logic [ADC_CODE_W-1:0] adc_code_t;
    typedef logic [CHAN_W-1:0]     chan_t;
    typedef logic [ALARM_W-1:0]    alarm_t;

    localparam int N_CHANNELS = 4;
    localparam int SAMPLES_W  = N_CHANNELS * ADC_CODE_W;  // Packed sample inputs
    localparam int CH_IDX_W   = $clog2(N_CHANNELS);
    localparam int CODE_SHIFT = DRP_DATA_W - ADC_CODE_W;  // Left-justify

    // Timing
    localparam int CONV_CYCLES = 16;  // Per enabled channel
    localparam int CNT_W       = $clog2(CONV_CYCLES);
    localparam int DRP_LATENCY = 2;   // den to drdy

    // ----------------------------------------------------------------------
    // Register map
    // ----------------------------------------------------------------------
    localparam drp_addr_t REG_RESULT0  = 7'h00;  // Through 7'h03
    localparam drp_addr_t REG_SEQ_MASK = 7'h48;
    localparam drp_addr_t REG_LIMIT0   = 7'h50;  // Through 7'h53
    localparam drp_addr_t REG_OT_LIMIT = 7'h58;

    localparam drp_data_t LIMIT_RESET = 16'hFFF0;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_CONVERT
    } seq_state_t;

endpackage

/* rtl/bus_pkg.sv */
package bus_pkg;

    // ----------------------------------------------------------------------
    // Native memory bus
    // ----------------------------------------------------------------------
    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;
    localparam int BUS_STRB_W = BUS_DATA_W / 8;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;
    typedef logic [BUS_STRB_W-1:0] bus_strb_t;

    // Address bits 31:24 pick the peripheral, bits 23:16 the window
    localparam logic [7:0] BASE_ADDR = 8'h01;
    localparam logic [7:0] WIN_DRP   = 8'h00;  // Register port into the converter
    localparam logic [7:0] WIN_SFR   = 8'h10;  // Status and control word

    // ----------------------------------------------------------------------
    // Status word layout
    // ----------------------------------------------------------------------
    localparam int SFR_BIT_BUSY    = 0;
    localparam int SFR_BIT_EOC     = 1;
    localparam int SFR_BIT_EOS     = 2;
    localparam int SFR_BIT_OT      = 4;
    localparam int SFR_LSB_CHANNEL = 8;
    localparam int SFR_LSB_ALARM   = 16;

    localparam int SFR_BIT_CORE_RESET = 0;  // Write side

    // Register port sequencing
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_WAIT,
        PORT_DONE
    } drp_state_t;

endpackage
